// File: Bender.yml
package:
  name: lc4_pipeline

sources:
  - include_dirs:
      - include
    files:
      - design/lc4_pkg.sv
      - design/lc4_decoder.sv
      - design/lc4_alu.sv
      - design/lc4_regfile.sv
      - design/lc4_hazard_unit.sv
      - design/lc4_pipeline.sv
  - target: test
    files:
      - verification/lc4_tb.sv

// File: design/lc4_alu.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_alu
    import lc4_pkg::*;
(
    input  word_t i_insn,
    input  word_t i_pc,
    input  word_t i_rs,
    input  word_t i_rt,
    output word_t o_result
);

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t jsr_target;

    assign imm5 = word_t'($signed(i_insn[4:0]));
    assign imm6 = word_t'($signed(i_insn[5:0]));
    assign imm9 = word_t'($signed(i_insn[8:0]));
    // keep the PC's top bit, the 11-bit immediate selects a 16-word block
    assign jsr_target = {i_pc[`LC4_WORD_W-1], i_insn[10:0], 4'b0000};

    always_comb begin
        case (opcode_t'(i_insn[`LC4_OP_HI:`LC4_OP_LO]))
            OP_BR: begin
                o_result = i_pc + word_t'(1) + imm9;
            end
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs + imm5;
                end else if (i_insn[5:3] == 3'b010) begin
                    o_result = i_rs - i_rt;
                end else begin
                    o_result = i_rs + i_rt;
                end
            end
            OP_LOGIC: o_result = i_rs & i_rt;
            // effective address, base plus offset
            OP_LDR, OP_STR: o_result = i_rs + imm6;
            OP_CONST: o_result = imm9;
            OP_JSR: o_result = jsr_target;
            default: o_result = '0;
        endcase
    end

endmodule

// File: design/lc4_decoder.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_decoder
    import lc4_pkg::*;
(
    input  word_t i_insn,
    output ctrl_t o_ctrl
);

    opcode_t    opcode;
    logic [2:0] sub_op;
    reg_idx_t   rd_field;
    reg_idx_t   rs_field;
    reg_idx_t   rt_field;
    logic       alu_op;

    assign opcode   = opcode_t'(i_insn[`LC4_OP_HI:`LC4_OP_LO]);
    assign sub_op   = i_insn[5:3];
    assign rd_field = i_insn[`LC4_RD_LO +: `LC4_REG_IDX_W];
    assign rs_field = i_insn[`LC4_RS_LO +: `LC4_REG_IDX_W];
    assign rt_field = i_insn[0 +: `LC4_REG_IDX_W];

    // ADD, SUB, ADD immediate and AND are the only kept register ops
    assign alu_op = (opcode == OP_ARITH && (i_insn[5] || sub_op == 3'b000 || sub_op == 3'b010))
                 || (opcode == OP_LOGIC && sub_op == 3'b000);

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.rs_sel = rs_field;
        // STR carries its data register in the destination field
        o_ctrl.rt_sel = (opcode == OP_STR) ? rd_field : rt_field;
        o_ctrl.rd_sel = (opcode == OP_JSR) ? reg_idx_t'(`LC4_JSR_REG) : rd_field;
        case (opcode)
            OP_BR: begin
                // an empty nzp mask is the NOP encoding
                o_ctrl.is_branch = |i_insn[11:9];
            end
            OP_ARITH, OP_LOGIC: begin
                if (alu_op) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = !(opcode == OP_ARITH && i_insn[5]);
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_JSR: begin
                // JSRR falls through as a NOP since only the immediate form is kept
                if (i_insn[11]) begin
                    o_ctrl.rf_we           = 1'b1;
                    o_ctrl.nzp_we          = 1'b1;
                    o_ctrl.sel_pc_plus_one = 1'b1;
                    o_ctrl.is_control      = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/lc4_hazard_unit.sv
`timescale 1ns/1ps

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  ctrl_t d_ctrl,
    input  ctrl_t x_ctrl,
    input  ctrl_t m_ctrl,
    input  ctrl_t w_ctrl,
    input  logic  i_x_taken,
    output byp_t  o_rs_byp,
    output byp_t  o_rt_byp,
    output logic  o_store_byp,
    output logic  o_stall,
    output logic  o_flush
);

    logic load_use;

    // newest producer wins, M before W before the register file
    function automatic byp_t pick_src(input reg_idx_t sel, input logic re,
                                      input ctrl_t m, input ctrl_t w);
        // a load in M has no data yet, stall or WM path covers it
        if (re && m.rf_we && !m.is_load && m.rd_sel == sel) begin
            return BYP_MEM;
        end
        if (re && w.rf_we && w.rd_sel == sel) begin
            return BYP_WB;
        end
        return BYP_REGFILE;
    endfunction

    assign o_rs_byp = pick_src(x_ctrl.rs_sel, x_ctrl.rs_re, m_ctrl, w_ctrl);
    assign o_rt_byp = pick_src(x_ctrl.rt_sel, x_ctrl.rt_re, m_ctrl, w_ctrl);

    // store data taken from the instruction just ahead of it
    assign o_store_byp = m_ctrl.is_store && w_ctrl.rf_we && w_ctrl.rd_sel == m_ctrl.rt_sel;

    // a store waits only when the loaded register is its base,
    // a branch waits for the NZP that the load sets in M
    assign load_use = x_ctrl.is_load
                   && ((d_ctrl.rs_re && d_ctrl.rs_sel == x_ctrl.rd_sel)
                   || (d_ctrl.rt_re && !d_ctrl.is_store && d_ctrl.rt_sel == x_ctrl.rd_sel)
                   || d_ctrl.is_branch);

    assign o_stall = load_use;
    assign o_flush = i_x_taken;

    // redirecting instructions are never loads, so both cannot coincide
    a_stall_flush_excl: assert #0 (!(o_stall && o_flush))
        else $error("stall and flush raised together");

endmodule

// File: design/lc4_pipeline.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_pipeline
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  word_t    i_imem_insn,
    input  word_t    i_dmem_rdata,
    output word_t    o_imem_addr,
    output word_t    o_dmem_addr,
    output word_t    o_dmem_wdata,
    output logic     o_dmem_we,
    output word_t    o_wb_pc,
    output word_t    o_wb_insn,
    output word_t    o_wb_data,
    output stall_t   o_wb_stall,
    output logic     o_wb_rf_we,
    output reg_idx_t o_wb_rd,
    output logic     o_wb_nzp_we,
    output nzp_t     o_wb_nzp
);

    word_t  pc;
    word_t  d_insn, d_pc, rf_rs, rf_rt;
    ctrl_t  d_ctrl;
    stall_t d_stall;
    word_t  x_insn, x_pc, x_rs, x_rt, x_rs_fwd, x_rt_fwd, x_alu, x_nzp_src;
    ctrl_t  x_ctrl;
    stall_t x_stall;
    logic   x_taken;
    byp_t   rs_byp, rt_byp;
    word_t  m_insn, m_pc, m_alu, m_rt, m_fwd;
    ctrl_t  m_ctrl;
    stall_t m_stall;
    nzp_t   m_nzp;
    logic   store_byp;
    word_t  w_insn, w_pc, w_alu, w_load, wb_data;
    ctrl_t  w_ctrl;
    stall_t w_stall;
    nzp_t   w_nzp, nzp_reg;
    logic   stall, flush;

    function automatic nzp_t nzp_of(input word_t v);
        return v[`LC4_WORD_W-1] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
    endfunction

    lc4_decoder u_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

    lc4_regfile u_regfile (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_sel(d_ctrl.rs_sel), .i_rt_sel(d_ctrl.rt_sel),
        .i_rd_sel(w_ctrl.rd_sel), .i_rd_we(w_ctrl.rf_we), .i_wdata(wb_data),
        .o_rs_data(rf_rs), .o_rt_data(rf_rt)
    );

    lc4_hazard_unit u_hazard (
        .d_ctrl(d_ctrl), .x_ctrl(x_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
        .i_x_taken(x_taken), .o_rs_byp(rs_byp), .o_rt_byp(rt_byp),
        .o_store_byp(store_byp), .o_stall(stall), .o_flush(flush)
    );

    lc4_alu u_alu (
        .i_insn(x_insn), .i_pc(x_pc), .i_rs(x_rs_fwd), .i_rt(x_rt_fwd), .o_result(x_alu)
    );

    // redirect has priority over the load-use hold in fetch
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `LC4_RESET_PC;
            d_insn  <= '0;
            d_pc    <= '0;
            d_stall <= STALL_FLUSH;
        end else if (flush) begin
            pc      <= x_alu;
            d_insn  <= '0;
            d_pc    <= '0;
            d_stall <= STALL_FLUSH;
        end else if (!stall) begin
            pc      <= pc + word_t'(1);
            d_insn  <= i_imem_insn;
            d_pc    <= pc;
            d_stall <= STALL_NONE;
        end
    end

    // a bubble enters execute on flush or load-use
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_insn  <= '0;
            x_pc    <= '0;
            x_ctrl  <= '0;
            x_rs    <= '0;
            x_rt    <= '0;
            x_stall <= STALL_FLUSH;
        end else if (flush || stall) begin
            x_insn  <= '0;
            x_pc    <= '0;
            x_ctrl  <= '0;
            x_stall <= flush ? STALL_FLUSH : STALL_LOAD;
        end else begin
            x_insn  <= d_insn;
            x_pc    <= d_pc;
            x_ctrl  <= d_ctrl;
            x_rs    <= rf_rs;
            x_rt    <= rf_rt;
            x_stall <= d_stall;
        end
    end

    assign m_fwd     = m_ctrl.sel_pc_plus_one ? m_pc + word_t'(1) : m_alu;
    assign wb_data   = w_ctrl.sel_pc_plus_one ? w_pc + word_t'(1)
                     : w_ctrl.is_load ? w_load : w_alu;
    assign x_rs_fwd  = (rs_byp == BYP_MEM) ? m_fwd : (rs_byp == BYP_WB) ? wb_data : x_rs;
    assign x_rt_fwd  = (rt_byp == BYP_MEM) ? m_fwd : (rt_byp == BYP_WB) ? wb_data : x_rt;
    assign x_nzp_src = x_ctrl.sel_pc_plus_one ? x_pc + word_t'(1) : x_alu;
    assign x_taken   = x_ctrl.is_control
                    || (x_ctrl.is_branch && |(nzp_reg & nzp_t'(x_insn[11:9])));

    // execute to memory to writeback and the NZP condition register
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_insn  <= '0;
            m_pc    <= '0;
            m_ctrl  <= '0;
            m_alu   <= '0;
            m_rt    <= '0;
            m_nzp   <= '0;
            m_stall <= STALL_FLUSH;
            w_insn  <= '0;
            w_pc    <= '0;
            w_ctrl  <= '0;
            w_alu   <= '0;
            w_load  <= '0;
            w_nzp   <= '0;
            w_stall <= STALL_FLUSH;
            nzp_reg <= 3'b010;
        end else begin
            m_insn  <= x_insn;
            m_pc    <= x_pc;
            m_ctrl  <= x_ctrl;
            m_alu   <= x_alu;
            m_rt    <= x_rt_fwd;
            m_nzp   <= nzp_of(x_nzp_src);
            m_stall <= x_stall;
            w_insn  <= m_insn;
            w_pc    <= m_pc;
            w_ctrl  <= m_ctrl;
            w_alu   <= m_alu;
            w_load  <= i_dmem_rdata;
            w_nzp   <= m_ctrl.is_load ? nzp_of(i_dmem_rdata) : m_nzp;
            w_stall <= m_stall;
            // younger writer in X overrides a load finishing in M
            if (x_ctrl.nzp_we && !x_ctrl.is_load) begin
                nzp_reg <= nzp_of(x_nzp_src);
            end else if (m_ctrl.is_load) begin
                nzp_reg <= nzp_of(i_dmem_rdata);
            end
        end
    end

    assign o_imem_addr  = pc;
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_alu : '0;
    assign o_dmem_wdata = !m_ctrl.is_store ? '0 : store_byp ? wb_data : m_rt;

    assign o_wb_pc     = w_pc;
    assign o_wb_insn   = w_insn;
    assign o_wb_data   = wb_data;
    assign o_wb_stall  = w_stall;
    assign o_wb_rf_we  = w_ctrl.rf_we;
    assign o_wb_rd     = w_ctrl.rd_sel;
    assign o_wb_nzp_we = w_ctrl.nzp_we;
    assign o_wb_nzp    = w_nzp;

    // only a real store slot in M writes memory
    a_store_in_m: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> m_stall == STALL_NONE && !$isunknown(o_dmem_addr));

    a_wb_data_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_wb_rf_we |-> !$isunknown(o_wb_data));

endmodule

// File: design/lc4_pkg.sv
`include "lc4_settings.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0]    word_t;
    typedef logic [`LC4_REG_IDX_W-1:0] reg_idx_t;
    // one-hot, bit 2 is negative, bit 0 is positive
    typedef logic [`LC4_NZP_W-1:0]     nzp_t;

    typedef enum logic [`LC4_OP_HI-`LC4_OP_LO:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_JSR   = 4'b0100,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    // PIPE is kept for the trace format, a single pipe never emits it
    typedef enum logic [`LC4_STALL_W-1:0] {
        STALL_NONE  = 2'd0,
        STALL_PIPE  = 2'd1,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_t;

    typedef struct packed {
        reg_idx_t rs_sel;
        reg_idx_t rt_sel;
        reg_idx_t rd_sel;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     sel_pc_plus_one;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     is_control;
    } ctrl_t;

    typedef enum logic [1:0] {
        BYP_REGFILE = 2'd0,
        BYP_MEM     = 2'd1,
        BYP_WB      = 2'd2
    } byp_t;

endpackage

// File: design/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  reg_idx_t i_rs_sel,
    input  reg_idx_t i_rt_sel,
    input  reg_idx_t i_rd_sel,
    input  logic     i_rd_we,
    input  word_t    i_wdata,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);

    word_t regs [`LC4_REG_N];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // writeback value is visible to decode in the same cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

    a_wsel_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_rd_we |-> !$isunknown(i_rd_sel));

endmodule

// File: include/lc4_settings.svh
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

// datapath word, used for data and for addresses
`define LC4_WORD_W      16

// general register file
`define LC4_REG_N       8
`define LC4_REG_IDX_W   3
// link register written by JSR
`define LC4_JSR_REG     7

// first fetch address after reset
`define LC4_RESET_PC    16'h8200

// instruction field positions
`define LC4_OP_HI       15
`define LC4_OP_LO       12
`define LC4_RD_LO       9
`define LC4_RS_LO       6

// retire trace field widths
`define LC4_STALL_W     2
`define LC4_NZP_W       3

`endif

// File: list.f
+incdir+include
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_alu.sv
design/lc4_regfile.sv
design/lc4_hazard_unit.sv
design/lc4_pipeline.sv
verification/lc4_tb.sv

// File: verification/lc4_golden.dat
// lc4 pipeline golden image, all values in hex
// header: program count, data count, trace count
0013_0002_001F
// program at 0x10: address, instruction
@10
8200_9205
8201_95FD
8202_1642
8203_18D1
8204_5B03
8205_1D27
8206_9040
8207_6202
8208_1446
8209_7403
820A_6603
820B_7604
820C_0605
820D_0802
8210_4823
8230_1FE1
8231_6805
8232_0201
8234_0FFF
// data at 0x40: address, value
@40
0042_8001
0045_0123
// trace at 0x50, one record per cycle after reset, fields are
// stall_pc_insn_rfwe_rd_data_nzpwe_nzp_store_storeaddr_storedata
@50
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
0_8200_9205_1_1_0005_1_1_0_0000_0000
0_8201_95FD_1_2_FFFD_1_4_0_0000_0000
0_8202_1642_1_3_0002_1_1_0_0000_0000
0_8203_18D1_1_4_FFFD_1_4_0_0000_0000
0_8204_5B03_1_5_0000_1_2_0_0000_0000
0_8205_1D27_1_6_0004_1_1_0_0000_0000
0_8206_9040_1_0_0040_1_1_0_0000_0000
0_8207_6202_1_1_8001_1_4_0_0000_0000
3_0000_0000_0_0_0000_0_0_0_0000_0000
0_8208_1446_1_2_8005_1_4_1_0043_8005
0_8209_7403_0_0_0000_0_0_0_0000_0000
0_820A_6603_1_3_8005_1_4_1_0044_8005
0_820B_7604_0_0_0000_0_0_0_0000_0000
0_820C_0605_0_0_0000_0_0_0_0000_0000
0_820D_0802_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
0_8210_4823_1_7_8211_1_4_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
0_8230_1FE1_1_7_8212_1_4_0_0000_0000
0_8231_6805_1_4_0123_1_1_0_0000_0000
3_0000_0000_0_0_0000_0_0_0_0000_0000
0_8232_0201_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
2_0000_0000_0_0_0000_0_0_0_0000_0000
0_8234_0FFF_0_0_0000_0_0_0_0000_0000

// File: verification/lc4_tb.sv
`timescale 1ns/1ps

module lc4_tb
    import lc4_pkg::*;
();

    // sections of the golden image
    localparam int PROG_BASE    = 'h10;
    localparam int DATA_BASE    = 'h40;
    localparam int TRACE_BASE   = 'h50;
    localparam int RESET_CYCLES = 16;
    // first fetch address after reset
    localparam word_t RESET_PC  = 16'h8200;

    logic     gwe;
    logic     i_arst_n;
    word_t    imem_insn;
    word_t    dmem_rdata;
    word_t    imem_addr;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_we;
    word_t    wb_pc;
    word_t    wb_insn;
    word_t    wb_data;
    stall_t   wb_stall;
    logic     wb_rf_we;
    reg_idx_t wb_rd;
    logic     wb_nzp_we;
    nzp_t     wb_nzp;

    word_t        imem [0:65535];
    word_t        dmem [0:65535];
    logic [103:0] golden [0:127];
    int           n_trace;
    int           limit = 0;
    int           cycle = 0;

    lc4_pipeline UUT (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_imem_insn(imem_insn), .i_dmem_rdata(dmem_rdata),
        .o_imem_addr(imem_addr), .o_dmem_addr(dmem_addr),
        .o_dmem_wdata(dmem_wdata), .o_dmem_we(dmem_we),
        .o_wb_pc(wb_pc), .o_wb_insn(wb_insn), .o_wb_data(wb_data),
        .o_wb_stall(wb_stall), .o_wb_rf_we(wb_rf_we), .o_wb_rd(wb_rd),
        .o_wb_nzp_we(wb_nzp_we), .o_wb_nzp(wb_nzp)
    );

    initial gwe = 1'b0;
    always #10 gwe = ~gwe;

    // both memories answer in the same cycle
    assign imem_insn  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    always @(posedge gwe) begin
        if (i_arst_n) begin
            cycle = cycle + 1;
            if (cycle > limit) begin
                $display("timeout: retire trace not finished within %0d cycles", limit);
                end_in_failure();
            end
        end
    end

    task automatic end_in_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected R%0d actual R%0d", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_nzp(input string name, input nzp_t exp, input nzp_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_stall(input string name, input stall_t exp, input stall_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            end_in_failure();
        end
    endtask

    // rd, data and nzp of a retire record only matter when their enable is set
    task automatic check_cycle(input int idx, input logic [103:0] rec);
        string tag;
        tag = $sformatf("cycle %0d", idx);
        check_stall({tag, " stall"}, stall_t'(rec[101:100]), wb_stall);
        check_word({tag, " pc"}, rec[99:84], wb_pc);
        check_word({tag, " insn"}, rec[83:68], wb_insn);
        check_bit({tag, " rf_we"}, rec[64], wb_rf_we);
        if (rec[64]) begin
            check_reg({tag, " rd"}, rec[62:60], wb_rd);
            check_word({tag, " data"}, rec[59:44], wb_data);
        end
        check_bit({tag, " nzp_we"}, rec[40], wb_nzp_we);
        if (rec[40]) begin
            check_nzp({tag, " nzp"}, rec[38:36], wb_nzp);
        end
        check_bit({tag, " dmem_we"}, rec[32], dmem_we);
        if (rec[32]) begin
            check_word({tag, " dmem_addr"}, rec[31:16], dmem_addr);
            check_word({tag, " dmem_wdata"}, rec[15:0], dmem_wdata);
        end
    endtask

    initial begin
        logic [103:0] rec;
        int           a;
        int           n_prog;
        int           n_data;
        i_arst_n = 1'b0;
        // unprogrammed words fetch as NOP
        for (a = 0; a < 65536; a++) begin
            imem[a] = '0;
            dmem[a] = word_t'(a) ^ 16'h5aa5;
        end
        $readmemh("verification/lc4_golden.dat", golden);
        rec     = golden[0];
        n_prog  = int'(rec[47:32]);
        n_data  = int'(rec[31:16]);
        n_trace = int'(rec[15:0]);
        if ($isunknown(rec) || n_trace == 0) begin
            $display("golden file is missing or holds no trace records");
            end_in_failure();
        end
        for (a = 0; a < n_prog; a++) begin
            rec = golden[PROG_BASE + a];
            imem[rec[31:16]] = rec[15:0];
        end
        for (a = 0; a < n_data; a++) begin
            rec = golden[DATA_BASE + a];
            dmem[rec[31:16]] = rec[15:0];
        end
        limit = n_trace + 20;

        repeat (RESET_CYCLES) @(posedge gwe);
        #2;
        i_arst_n = 1'b1;

        // outputs are settled half a period after each edge
        for (a = 0; a < n_trace; a++) begin
            @(negedge gwe);
            if (a == 0) begin
                check_word("reset imem_addr", RESET_PC, imem_addr);
            end
            check_cycle(a, golden[TRACE_BASE + a]);
        end
        $display("No errors");
        $finish;
    end

endmodule
